// File: common/sbus_pkg.sv
// Shared serial bus definitions
`default_nettype none

package sbus_pkg;

    ////////////////////////////////////////
    // field widths

    // one byte per transfer
    localparam int DATA_WIDTH = 8;

    localparam int ADDR_WIDTH = 12;
    localparam int SLAVE_ID_WIDTH = 3;

    // rw bit, slave id, address
    localparam int HEADER_WIDTH = 1 + SLAVE_ID_WIDTH + ADDR_WIDTH;

    // live masters on the line
    localparam int N_MASTERS = 2;

    ////////////////////////////////////////
    // slave ids

    localparam logic [SLAVE_ID_WIDTH-1:0] SLAVE_A_ID = 3'd3;
    localparam logic [SLAVE_ID_WIDTH-1:0] SLAVE_B_ID = 3'd4;

    ////////////////////////////////////////
    // payload types

    typedef logic [DATA_WIDTH-1:0] data_t;

    // parallel request into a master
    typedef struct packed {
        logic                      write;   // 1 = write, 0 = read
        logic [SLAVE_ID_WIDTH-1:0] slave_id;
        logic [ADDR_WIDTH-1:0]     addr;
        data_t                     wdata;
    } mem_req_t;

    // header as sent on the line, msb first
    typedef struct packed {
        logic                      write;
        logic [SLAVE_ID_WIDTH-1:0] slave_id;
        logic [ADDR_WIDTH-1:0]     addr;
    } bus_header_t;

    // one driver's share of the line
    // idle driver gives zeros so drivers join by or
    typedef struct packed {
        logic active;   // frame in progress
        logic data;
    } bus_line_t;

endpackage

`default_nettype wire

// File: source/serial_shifter.sv
// Loadable msb-first shift register
`timescale 1ns/1ps
`default_nettype none

module serial_shifter #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     load,
    input  wire payload_t load_value,
    input  wire logic     shift,
    input  wire logic     shift_in,
    output logic          shift_out,
    output payload_t      value
);

    localparam int W = $bits(payload_t);

    logic [W-1:0] shreg;

    // load wins over shift
    // new bits enter at the lsb, oldest leaves at the msb
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shreg <= '0;
        end else if (load) begin
            shreg <= load_value;
        end else if (shift) begin
            shreg <= {shreg[W-2:0], shift_in};
        end
    end

    // serializer side
    assign shift_out = shreg[W-1];

    // deserializer side
    assign value = payload_t'(shreg);

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
// Fixed priority bus arbiter
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
    parameter int N_MASTERS = 2
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic [N_MASTERS-1:0] request,
    output logic [N_MASTERS-1:0]      grant,
    output logic                      bus_util
);

    logic [N_MASTERS-1:0] pick;
    logic                 found;
    logic                 held;

    ////////////////////////////////////////
    // priority pick

    // lowest index requester wins
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (request[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    // owner still asking for the line
    assign held = |(grant & request);

    ////////////////////////////////////////
    // grant register

    // new grant only from a free bus
    // owner keeps it until its request falls
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant <= '0;
        end else if (|grant) begin
            if (!held) begin
                grant <= '0;
            end
        end else begin
            grant <= pick;
        end
    end

    // line in use while anyone holds it
    assign bus_util = |grant;

endmodule

`default_nettype wire

// File: master/bus_master.sv
// Serial bus master engine
`timescale 1ns/1ps
`default_nettype none

module bus_master import sbus_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      req_valid,
    input  wire mem_req_t  req,
    input  wire logic      grant,
    input  wire bus_line_t rsp_line,
    output logic           request,
    output bus_line_t      fwd_line,
    output logic           busy,
    output logic           done,
    output logic           rsp_valid,
    output data_t          rsp_data
);

    localparam int CNT_W = $clog2(HEADER_WIDTH);
    localparam int TIMEOUT_CYCLES = 16;
    localparam int TMO_W = $clog2(TIMEOUT_CYCLES);
    localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(HEADER_WIDTH - 1);
    localparam logic [CNT_W-1:0] BYTE_LAST = CNT_W'(DATA_WIDTH - 1);
    localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(TIMEOUT_CYCLES - 1);

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT, S_HEADER, S_WDATA, S_TURN, S_RDATA, S_FINISH
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   bit_cnt;
    logic [TMO_W-1:0]   tmo_cnt;
    logic               is_write;
    logic               accept;
    logic               hdr_phase;
    logic               hdr_out;
    logic               byte_out;
    logic               rx_clear;
    bus_header_t        hdr_load;

    // finish acts as idle for a new strobe
    assign accept    = req_valid && (state == S_IDLE || state == S_FINISH);
    // first header bit goes out in the grant cycle
    assign hdr_phase = (state == S_WAIT && grant) || state == S_HEADER;
    // silent slave, give up with zero data
    assign rx_clear  = state == S_RDATA && !rsp_line.active && tmo_cnt == TMO_LAST;
    assign hdr_load  = {req.write, req.slave_id, req.addr};

    ////////////////////////////////////////
    // shifters

    serial_shifter #(.payload_t(bus_header_t)) u_hdr_tx (
        .clk(clk), .arst_n(arst_n), .load(accept), .load_value(hdr_load),
        .shift(hdr_phase), .shift_in(1'b0), .shift_out(hdr_out), .value()
    );

    serial_shifter #(.payload_t(data_t)) u_byte_tx (
        .clk(clk), .arst_n(arst_n), .load(accept), .load_value(req.wdata),
        .shift(state == S_WDATA), .shift_in(1'b0), .shift_out(byte_out), .value()
    );

    // read byte in, also holds rsp_data
    serial_shifter #(.payload_t(data_t)) u_byte_rx (
        .clk(clk), .arst_n(arst_n), .load(rx_clear), .load_value('0),
        .shift(state == S_RDATA && rsp_line.active), .shift_in(rsp_line.data),
        .shift_out(), .value(rsp_data)
    );

    ////////////////////////////////////////
    // transaction FSM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            tmo_cnt  <= '0;
            is_write <= 1'b0;
        end else begin
            case (state)
                S_IDLE, S_FINISH: begin
                    state <= accept ? S_WAIT : S_IDLE;
                    if (accept) is_write <= req.write;
                end
                S_WAIT: if (grant) begin
                    state   <= S_HEADER;
                    bit_cnt <= CNT_W'(1);
                end
                S_HEADER: if (bit_cnt == HDR_LAST) begin
                    state   <= is_write ? S_WDATA : S_TURN;
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                S_WDATA: if (bit_cnt == BYTE_LAST) state <= S_FINISH;
                    else bit_cnt <= bit_cnt + 1'b1;
                // line changes hands here
                S_TURN: begin
                    state   <= S_RDATA;
                    bit_cnt <= '0;
                    tmo_cnt <= '0;
                end
                S_RDATA: if (rsp_line.active) begin
                    if (bit_cnt == BYTE_LAST) state <= S_FINISH;
                    else bit_cnt <= bit_cnt + 1'b1;
                end else if (tmo_cnt == TMO_LAST) begin
                    state <= S_FINISH;
                end else begin
                    tmo_cnt <= tmo_cnt + 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // outputs

    // drive only while granted and sending
    always_comb begin
        fwd_line = '0;
        if (hdr_phase) begin
            fwd_line.active = 1'b1;
            fwd_line.data   = hdr_out;
        end else if (state == S_WDATA) begin
            fwd_line.active = 1'b1;
            fwd_line.data   = byte_out;
        end
    end

    assign busy      = state != S_IDLE && state != S_FINISH;
    assign request   = busy;
    assign done      = state == S_FINISH && is_write;
    assign rsp_valid = state == S_FINISH && !is_write;

endmodule

`default_nettype wire

// File: slave/memory_slave.sv
// Serial bus memory slave
`timescale 1ns/1ps
`default_nettype none

module memory_slave import sbus_pkg::*; #(
    parameter logic [SLAVE_ID_WIDTH-1:0] SELF_ID = SLAVE_A_ID,
    parameter int MEM_ADDR_BITS = 6
) (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire bus_line_t fwd_line,
    output bus_line_t      rsp_line
);

    localparam int MEM_DEPTH = 1 << MEM_ADDR_BITS;
    localparam int CNT_W = $clog2(HEADER_WIDTH);
    localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(HEADER_WIDTH - 1);
    localparam logic [CNT_W-1:0] BYTE_LAST = CNT_W'(DATA_WIDTH - 1);

    typedef enum logic [2:0] {
        S_IDLE, S_HDR, S_SKIP, S_WDATA, S_TURN, S_RDATA
    } state_t;

    state_t              state;
    logic [CNT_W-1:0]    bit_cnt;
    data_t               mem [MEM_DEPTH];
    bus_header_t         hdr_value;
    bus_header_t         hdr_next;
    data_t               wr_value;
    logic                hdr_shift;
    logic                hdr_end;
    logic                rd_load;
    logic                rd_out;
    logic                mem_we;

    // header gathers from the first active bit
    assign hdr_shift = fwd_line.active && (state == S_IDLE || state == S_HDR);
    // header with the bit arriving now
    assign hdr_next  = {hdr_value[HEADER_WIDTH-2:0], fwd_line.data};
    assign hdr_end   = state == S_HDR && fwd_line.active && bit_cnt == HDR_LAST;
    assign rd_load   = hdr_end && hdr_next.slave_id == SELF_ID && !hdr_next.write;
    // store on the last data bit
    assign mem_we    = state == S_WDATA && fwd_line.active && bit_cnt == BYTE_LAST;

    ////////////////////////////////////////
    // shifters

    serial_shifter #(.payload_t(bus_header_t)) u_hdr_rx (
        .clk(clk), .arst_n(arst_n), .load(1'b0), .load_value('0),
        .shift(hdr_shift), .shift_in(fwd_line.data), .shift_out(), .value(hdr_value)
    );

    serial_shifter #(.payload_t(data_t)) u_byte_rx (
        .clk(clk), .arst_n(arst_n), .load(1'b0), .load_value('0),
        .shift(state == S_WDATA && fwd_line.active), .shift_in(fwd_line.data),
        .shift_out(), .value(wr_value)
    );

    // aliased above the stored depth
    serial_shifter #(.payload_t(data_t)) u_byte_tx (
        .clk(clk), .arst_n(arst_n), .load(rd_load),
        .load_value(mem[hdr_next.addr[MEM_ADDR_BITS-1:0]]),
        .shift(state == S_RDATA), .shift_in(1'b0), .shift_out(rd_out), .value()
    );

    // byte store
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_we) begin
            mem[hdr_value.addr[MEM_ADDR_BITS-1:0]] <= {wr_value[DATA_WIDTH-2:0], fwd_line.data};
        end
    end

    ////////////////////////////////////////
    // frame FSM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: if (fwd_line.active) begin
                    state   <= S_HDR;
                    bit_cnt <= CNT_W'(1);
                end
                S_HDR: if (!fwd_line.active) begin
                    state <= S_IDLE;
                end else if (hdr_end) begin
                    bit_cnt <= '0;
                    if (hdr_next.slave_id != SELF_ID) state <= S_SKIP;
                    else state <= hdr_next.write ? S_WDATA : S_TURN;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                // someone else's frame, wait for the line to go quiet
                S_SKIP: if (!fwd_line.active) state <= S_IDLE;
                S_WDATA: if (!fwd_line.active || mem_we) state <= S_IDLE;
                    else bit_cnt <= bit_cnt + 1'b1;
                S_TURN: state <= S_RDATA;
                S_RDATA: if (bit_cnt == BYTE_LAST) state <= S_IDLE;
                    else bit_cnt <= bit_cnt + 1'b1;
                default: state <= S_IDLE;
            endcase
        end
    end

    // return line only during read data
    always_comb begin
        rsp_line = '0;
        if (state == S_RDATA) begin
            rsp_line.active = 1'b1;
            rsp_line.data   = rd_out;
        end
    end

endmodule

`default_nettype wire

// File: source/sbus_top.sv
// Shared serial bus top level
`timescale 1ns/1ps
`default_nettype none

module sbus_top import sbus_pkg::*; #(
    parameter int MEM_ADDR_BITS = 6
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic [N_MASTERS-1:0]     req_valid,
    input  wire mem_req_t [N_MASTERS-1:0] req,
    output logic [N_MASTERS-1:0]          busy,
    output logic [N_MASTERS-1:0]          done,
    output logic [N_MASTERS-1:0]          rsp_valid,
    output logic [N_MASTERS-1:0]          grant,
    output data_t [N_MASTERS-1:0]         rsp_data,
    output logic                          bus_util
);

    logic [N_MASTERS-1:0]      request;
    bus_line_t [N_MASTERS-1:0] master_line;
    bus_line_t                 fwd_line;
    bus_line_t                 slave_a_line;
    bus_line_t                 slave_b_line;
    bus_line_t                 rsp_line;

    ////////////////////////////////////////
    // arbitration

    bus_arbiter #(.N_MASTERS(N_MASTERS)) u_bus_arbiter (
        .clk(clk), .arst_n(arst_n), .request(request), .grant(grant), .bus_util(bus_util)
    );

    ////////////////////////////////////////
    // masters

    for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
        bus_master u_bus_master (
            .clk(clk), .arst_n(arst_n),
            .req_valid(req_valid[m]), .req(req[m]),
            .grant(grant[m]), .rsp_line(rsp_line),
            .request(request[m]), .fwd_line(master_line[m]),
            .busy(busy[m]), .done(done[m]),
            .rsp_valid(rsp_valid[m]), .rsp_data(rsp_data[m])
        );
    end

    // forward line, wired or of the masters
    always_comb begin
        fwd_line = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            fwd_line = fwd_line | master_line[m];
        end
    end

    ////////////////////////////////////////
    // slaves

    memory_slave #(.SELF_ID(SLAVE_A_ID), .MEM_ADDR_BITS(MEM_ADDR_BITS)) u_slave_a (
        .clk(clk), .arst_n(arst_n), .fwd_line(fwd_line), .rsp_line(slave_a_line)
    );

    memory_slave #(.SELF_ID(SLAVE_B_ID), .MEM_ADDR_BITS(MEM_ADDR_BITS)) u_slave_b (
        .clk(clk), .arst_n(arst_n), .fwd_line(fwd_line), .rsp_line(slave_b_line)
    );

    // return line seen by both masters
    assign rsp_line = slave_a_line | slave_b_line;

endmodule

`default_nettype wire

// File: sim/sbus_props.sv
// Shared bus protocol properties
`timescale 1ns/1ps
`default_nettype none

module sbus_props import sbus_pkg::*; (
    input wire logic                 clk,
    input wire logic                 arst_n,
    input wire logic [N_MASTERS-1:0] req_valid,
    input wire logic [N_MASTERS-1:0] busy,
    input wire logic [N_MASTERS-1:0] grant,
    input wire logic                 bus_util,
    input wire bus_line_t            fwd_line
);

    ////////////////////////////////////////
    // arbiter side

    // at most one owner of the line
    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant))
        else $error("grant is neither zero nor one-hot");

    // forward line only driven while the bus is in use
    a_line_owned: assert property (@(posedge clk) disable iff (!arst_n)
        fwd_line.active |-> bus_util)
        else $error("forward line active while the bus is not in use");

    ////////////////////////////////////////
    // master side

    // strobe on an idle master starts a transaction
    for (genvar m = 0; m < N_MASTERS; m++) begin : g_busy
        a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
            req_valid[m] && !busy[m] |=> busy[m])
            else $error("busy did not rise after a strobe on master %0d", m);
    end

endmodule

bind sbus_top sbus_props u_sbus_props (
    .clk(clk), .arst_n(arst_n), .req_valid(req_valid),
    .busy(busy), .grant(grant), .bus_util(bus_util), .fwd_line(fwd_line)
);

`default_nettype wire

// File: sim/tb_sbus_top.sv
// Serial bus directed testbench
`timescale 1ns/1ps
`default_nettype none

module tb_sbus_top import sbus_pkg::*; ();

    localparam int TIMEOUT = 200;
    // stored address bits per slave
    localparam int MODEL_BITS = 6;

    logic                     clk;
    logic                     arst_n;
    logic [N_MASTERS-1:0]     req_valid;
    mem_req_t [N_MASTERS-1:0] req;
    logic [N_MASTERS-1:0]     busy;
    logic [N_MASTERS-1:0]     done;
    logic [N_MASTERS-1:0]     rsp_valid;
    logic [N_MASTERS-1:0]     grant;
    data_t [N_MASTERS-1:0]    rsp_data;
    logic                     bus_util;

    // reference memory per slave id
    data_t       ref_mem [8][1 << MODEL_BITS];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    sbus_top #(.MEM_ADDR_BITS(MODEL_BITS)) u_sbus_top (
        .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req(req),
        .busy(busy), .done(done), .rsp_valid(rsp_valid), .grant(grant),
        .rsp_data(rsp_data), .bus_util(bus_util)
    );

    // 20 ns period
    always #10 clk = ~clk;

    ////////////////////////////////////////
    // helpers

    function automatic data_t next_rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // unknown ids never answer and read as zero
    function automatic data_t expected_read(input logic [2:0] id, input logic [11:0] addr);
        if (id == SLAVE_A_ID || id == SLAVE_B_ID) return ref_mem[id][addr[MODEL_BITS-1:0]];
        return '0;
    endfunction

    function automatic logic probe(input string what, input int m);
        case (what)
            "done": return done[m];
            "rsp_valid": return rsp_valid[m];
            "grant": return |grant;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // polls once per cycle just after the edge
    task automatic wait_for(input string what, input int m, output int cycles, output bit ok);
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            ok = probe(what, m);
        end
        if (!ok) begin
            $display("timeout: %s on master %0d never went high", what, m);
            errors++;
        end
    endtask

    // set up a request and track writes to known slaves
    task automatic load_request(input int m, input logic write, input logic [2:0] id,
                                input logic [11:0] addr, input data_t wdata);
        req[m] = '{write: write, slave_id: id, addr: addr, wdata: wdata};
        req_valid[m] = 1'b1;
        if (write && (id == SLAVE_A_ID || id == SLAVE_B_ID))
            ref_mem[id][addr[MODEL_BITS-1:0]] = wdata;
    endtask

    // single-cycle strobe
    task automatic release_strobe();
        @(posedge clk);
        #1;
        req_valid = '0;
    endtask

    task automatic write_byte(input int m, input logic [2:0] id, input logic [11:0] addr,
                              input data_t wdata, output int cycles);
        bit ok;
        load_request(m, 1'b1, id, addr, wdata);
        release_strobe();
        wait_for("done", m, cycles, ok);
        // strobe cycle counts too
        cycles++;
        if (ok) check_value($sformatf("busy[%0d]", m), 32'(busy[m]), 32'd0);
    endtask

    task automatic read_byte(input int m, input logic [2:0] id, input logic [11:0] addr);
        int    cycles;
        bit    ok;
        data_t exp;
        exp = expected_read(id, addr);
        load_request(m, 1'b0, id, addr, '0);
        release_strobe();
        wait_for("rsp_valid", m, cycles, ok);
        if (ok) begin
            check_value($sformatf("rsp_data[%0d]", m), 32'(rsp_data[m]), 32'(exp));
            check_value($sformatf("busy[%0d]", m), 32'(busy[m]), 32'd0);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    ////////////////////////////////////////
    // directed tests

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        check_value("grant", 32'(grant), 32'd0);
        check_value("bus_util", 32'(bus_util), 32'd0);
        report_test("reset state", e0);
    endtask

    task automatic test_write_read();
        int e0;
        int cycles;
        e0 = errors;
        write_byte(0, SLAVE_A_ID, 12'h005, next_rand_byte(), cycles);
        read_byte(0, SLAVE_A_ID, 12'h005);
        report_test("write then read back", e0);
    endtask

    task automatic test_slave_separation();
        int    e0;
        int    cycles;
        data_t a;
        data_t b;
        e0 = errors;
        a = next_rand_byte();
        b = next_rand_byte();
        if (b == a) b = ~a;
        idle_cycles(2);
        write_byte(0, SLAVE_A_ID, 12'h021, a, cycles);
        write_byte(1, SLAVE_B_ID, 12'h021, b, cycles);
        read_byte(1, SLAVE_A_ID, 12'h021);
        read_byte(0, SLAVE_B_ID, 12'h021);
        // never written
        read_byte(0, SLAVE_B_ID, 12'h03e);
        // aliases onto address 5
        read_byte(1, SLAVE_A_ID, 12'h0c5);
        report_test("slave separation", e0);
    endtask

    task automatic test_arbitration();
        int    e0;
        int    cycles;
        bit    ok;
        data_t exp1;
        e0 = errors;
        idle_cycles(2);
        exp1 = expected_read(SLAVE_A_ID, 12'h005);
        // both strobed in the same cycle
        load_request(0, 1'b1, SLAVE_B_ID, 12'h007, next_rand_byte());
        load_request(1, 1'b0, SLAVE_A_ID, 12'h005, '0);
        release_strobe();
        wait_for("grant", 0, cycles, ok);
        if (ok) begin
            check_value("grant", 32'(grant), 32'd1);
            check_value("bus_util", 32'(bus_util), 32'd1);
        end
        wait_for("done", 0, cycles, ok);
        wait_for("rsp_valid", 1, cycles, ok);
        if (ok) check_value("rsp_data[1]", 32'(rsp_data[1]), 32'(exp1));
        read_byte(1, SLAVE_B_ID, 12'h007);
        report_test("arbitration", e0);
    endtask

    task automatic test_latency();
        int e0;
        int cycles;
        e0 = errors;
        idle_cycles(3);
        write_byte(1, SLAVE_A_ID, 12'h028, next_rand_byte(), cycles);
        // strobe, grant, 16 header bits, 8 data bits
        check_value("done latency", 32'(cycles), 32'd26);
        read_byte(0, SLAVE_A_ID, 12'h028);
        report_test("latency bound", e0);
    endtask

    task automatic test_unknown_slave();
        int e0;
        e0 = errors;
        idle_cycles(2);
        // ends through the master's timeout
        read_byte(0, 3'd6, 12'h005);
        report_test("unknown slave", e0);
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        req_valid = '0;
        req = '0;
        lcg_state = 32'hd107;
        errors = 0;
        checks = 0;
        for (int s = 0; s < 8; s++) begin
            for (int a = 0; a < (1 << MODEL_BITS); a++) begin
                ref_mem[s][a] = '0;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset();
        test_write_read();
        test_slave_separation();
        test_arbitration();
        test_latency();
        test_unknown_slave();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
common/sbus_pkg.sv
source/serial_shifter.sv
source/bus_arbiter.sv
master/bus_master.sv
slave/memory_slave.sv
source/sbus_top.sv
sim/sbus_props.sv
sim/tb_sbus_top.sv

// File: Makefile
# Verilator build and run for the serial bus testbench

TOP := tb_sbus_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
